/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = periph_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Verification passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) --binary -j 0 $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Exit status comes from the search for the pass line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
hw/periph_pkg.sv
hw/apb_front.sv
hw/periph_decode.sv
hw/gpio_regs.sv
hw/rng_fifo.sv
hw/irq_gateway.sv
hw/periph_top.sv
verification/periph_tb.sv

/* hw/apb_front.sv */
// APB slave front end.
// Captures each access phase once into a request, then waits for the
// target answer and returns it with a single-cycle PREADY.
`timescale 1ns/10ps

module apb_front (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic [periph_pkg::AddrWidth-1:0]    paddr_i,
    input  logic [periph_pkg::DataWidth-1:0]    pwdata_i,
    input  logic                                psel_i,
    input  logic                                penable_i,
    input  logic                                pwrite_i,
    output logic [periph_pkg::DataWidth-1:0]    prdata_o,
    output logic                                pready_o,
    output logic                                pslverr_o,
    output periph_pkg::periph_req_t             req_o,
    input  periph_pkg::periph_rsp_t             rsp_i,
    input  logic                                rsp_valid_i
);

    periph_pkg::periph_req_t req_q;   // Captured access
    logic                    valid_q;
    logic                    busy_q;  // Access in flight
    logic                    capture;

    // Held access must not be taken again, nor in its PREADY cycle
    assign capture = psel_i && penable_i && !busy_q && !pready_o;

    // ------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            valid_q   <= 1'b0;
            busy_q    <= 1'b0;
            pready_o  <= 1'b0;
            pslverr_o <= 1'b0;
        end
        else
        begin
            valid_q   <= capture;                     // One-cycle pulse
            pready_o  <= rsp_valid_i;
            pslverr_o <= rsp_valid_i && rsp_i.error;  // Only with PREADY
            if (capture)
                busy_q <= 1'b1;
            else if (rsp_valid_i)
                busy_q <= 1'b0;
        end
    end

    // Payload
    always_ff @(posedge clk_i)
    begin
        if (capture)
        begin
            req_q.valid  <= 1'b1;
            req_q.write  <= pwrite_i;
            req_q.addr   <= paddr_i;
            req_q.wdata  <= pwdata_i;
            req_q.target <= periph_pkg::TgtNone; // Filled in by decode
        end
        if (rsp_valid_i)
            prdata_o <= rsp_i.rdata;
    end

    always_comb
    begin
        req_o       = req_q;
        req_o.valid = valid_q;
    end

    // PREADY only inside an access phase the master still holds
    a_pready_in_access : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        pready_o |-> (psel_i && penable_i)
    );

endmodule

/* hw/gpio_regs.sv */
// GPIO register target.
// LED output register at OffLed, DIP switch readback at OffDip.
`timescale 1ns/10ps

module gpio_regs (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  periph_pkg::periph_req_t             req_i,
    output periph_pkg::periph_rsp_t             rsp_o,
    input  logic [periph_pkg::LedWidth-1:0]     dip_i,
    output logic [periph_pkg::LedWidth-1:0]     leds_o
);

    logic sel;

    assign sel = req_i.valid && (req_i.target == periph_pkg::TgtGpio);

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
            leds_o <= '0;
        else if (sel && req_i.write && (req_i.addr == periph_pkg::OffLed))
            leds_o <= req_i.wdata[periph_pkg::LedWidth-1:0];
    end

    // Read data and error
    always_comb
    begin
        rsp_o.rdata = '0;
        rsp_o.error = 1'b0;
        case (req_i.addr)
            periph_pkg::OffLed:
                rsp_o.rdata[periph_pkg::LedWidth-1:0] = leds_o;
            periph_pkg::OffDip:
            begin
                rsp_o.rdata[periph_pkg::LedWidth-1:0] = dip_i;
                rsp_o.error = req_i.write;                  // Switches are read only
            end
            default:
            begin
                rsp_o.rdata = periph_pkg::BadData;
                rsp_o.error = 1'b1;
            end
        endcase
    end

endmodule

/* hw/irq_gateway.sv */
// Level-triggered interrupt gateway, a reduced PLIC.
// Sources latch into pending, a claim read hands out the lowest enabled ID,
// a write of that ID to the claim register completes it.
`timescale 1ns/10ps

module irq_gateway (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  periph_pkg::periph_req_t         req_i,
    output periph_pkg::periph_rsp_t         rsp_o,
    input  logic [periph_pkg::NumIrq-1:0]   src_i,
    output logic                            irq_o
);

    localparam int IdWidth = $clog2(periph_pkg::NumIrq + 1);

    logic [periph_pkg::NumIrq-1:0] pending_q, enable_q, in_service_q;
    logic [periph_pkg::NumIrq-1:0] claim_mask, complete_mask;
    logic [IdWidth-1:0]            claim_id;
    logic                          sel, claim, complete;

    assign sel      = req_i.valid && (req_i.target == periph_pkg::TgtIrq);
    assign claim    = sel && !req_i.write && (req_i.addr == periph_pkg::OffIrqClaim);
    assign complete = sel && req_i.write && (req_i.addr == periph_pkg::OffIrqClaim);
    assign irq_o    = |(pending_q & enable_q);

    // Lowest pending and enabled ID, 0 if none
    always_comb
    begin
        claim_id      = '0;
        claim_mask    = '0;
        complete_mask = '0;
        for (int i = periph_pkg::NumIrq - 1; i >= 0; i--)
        begin
            if (pending_q[i] && enable_q[i])
                claim_id = IdWidth'(i + 1);
            if (req_i.wdata == periph_pkg::DataWidth'(i + 1))
                complete_mask[i] = complete;
        end
        if (claim && (claim_id != '0))
            claim_mask[claim_id - IdWidth'(1)] = 1'b1;
    end

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            pending_q    <= '0;
            enable_q     <= '0;
            in_service_q <= '0;
        end
        else
        begin
            pending_q    <= (pending_q | (src_i & ~in_service_q)) & ~claim_mask; // Claim wins
            in_service_q <= (in_service_q | claim_mask) & ~complete_mask;
            if (sel && req_i.write && (req_i.addr == periph_pkg::OffIrqEn))
                enable_q <= req_i.wdata[periph_pkg::NumIrq-1:0];
        end
    end

    always_comb
    begin
        rsp_o.rdata = '0;
        rsp_o.error = 1'b0;
        case (req_i.addr)
            periph_pkg::OffIrqEn:    rsp_o.rdata[periph_pkg::NumIrq-1:0] = enable_q;
            periph_pkg::OffIrqPend:
            begin
                rsp_o.rdata[periph_pkg::NumIrq-1:0] = pending_q;
                rsp_o.error = req_i.write;
            end
            periph_pkg::OffIrqClaim: rsp_o.rdata[IdWidth-1:0] = claim_id;
            default:
            begin
                rsp_o.rdata = periph_pkg::BadData;
                rsp_o.error = 1'b1;
            end
        endcase
    end

    // ID on the bus names an enabled source that is not already in service
    a_claim_enabled : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (claim && (rsp_o.rdata != '0))
            |-> (enable_q[rsp_o.rdata[IdWidth-1:0] - IdWidth'(1)]
                 && !in_service_q[rsp_o.rdata[IdWidth-1:0] - IdWidth'(1)])
    );

endmodule

/* hw/periph_decode.sv */
// Address decode stage.
// Tags the captured request with its target and registers it.
// The registered valid also marks the cycle in which targets answer.
`timescale 1ns/10ps

module periph_decode (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  periph_pkg::periph_req_t req_i,
    output periph_pkg::periph_req_t req_o
);

    periph_pkg::periph_req_t req_q;
    periph_pkg::target_e     target;
    logic                    valid_q;

    // Offset to target
    always_comb
    begin
        if (req_i.addr[1:0] != 2'b00)
            target = periph_pkg::TgtNone;                       // Misaligned
        else
        begin
            case (req_i.addr)
                periph_pkg::OffLed,
                periph_pkg::OffDip:      target = periph_pkg::TgtGpio;
                periph_pkg::OffRngData,
                periph_pkg::OffRngStat:  target = periph_pkg::TgtRng;
                periph_pkg::OffIrqEn,
                periph_pkg::OffIrqPend,
                periph_pkg::OffIrqClaim: target = periph_pkg::TgtIrq;
                default:                 target = periph_pkg::TgtNone;
            endcase
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
            valid_q <= 1'b0;
        else
            valid_q <= req_i.valid;
    end

    always_ff @(posedge clk_i)
    begin
        req_q        <= req_i;
        req_q.target <= target;
    end

    always_comb
    begin
        req_o       = req_q;
        req_o.valid = valid_q;
    end

endmodule

/* hw/periph_pkg.sv */
// Shared definitions for the APB peripheral block.
// Register map, bus widths, request/response structs and interrupt IDs.
// Modules refer to these by scoped name.
package periph_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    localparam int AddrWidth = 8;
    localparam int DataWidth = 32;
    localparam int LedWidth  = 8;
    localparam int NumIrq    = 3;

    // ------------------------------------------------------------------
    // Register byte offsets
    // ------------------------------------------------------------------
    localparam logic [AddrWidth-1:0] OffLed      = 8'h00; // RW
    localparam logic [AddrWidth-1:0] OffDip      = 8'h04; // RO
    localparam logic [AddrWidth-1:0] OffRngData  = 8'h08; // Read pops FIFO
    localparam logic [AddrWidth-1:0] OffRngStat  = 8'h0C; // Status, write sets enable
    localparam logic [AddrWidth-1:0] OffIrqEn    = 8'h10; // RW
    localparam logic [AddrWidth-1:0] OffIrqPend  = 8'h14; // RO
    localparam logic [AddrWidth-1:0] OffIrqClaim = 8'h18; // Read claims, write completes

    // Returned on any error
    localparam logic [DataWidth-1:0] BadData = 32'hDEAD_BEEF;

    // Pins 0 and 1 map to IDs 1 and 2, FIFO full is the last source
    localparam int IrqIdRng = 3;

    // Target select
    typedef enum logic [1:0] {
        TgtGpio = 2'd0,
        TgtRng  = 2'd1,
        TgtIrq  = 2'd2,
        TgtNone = 2'd3
    } target_e;

    // One register access on its way through the pipeline
    typedef struct packed {
        logic                 valid;
        logic                 write;
        logic [AddrWidth-1:0] addr;
        logic [DataWidth-1:0] wdata;
        target_e              target;
    } periph_req_t;

    // Answer from a target
    typedef struct packed {
        logic [DataWidth-1:0] rdata;
        logic                 error;
    } periph_rsp_t;

endpackage

/* hw/periph_top.sv */
// Top level of the APB peripheral block.
// APB access flows capture -> decode -> target -> response, PREADY after 3 cycles.
// Targets are the GPIO registers, the RNG FIFO and the interrupt gateway.
`timescale 1ns/10ps

module periph_top #(
    parameter int RngDepth = 8
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    // APB slave port
    input  logic [periph_pkg::AddrWidth-1:0]    paddr_i,
    input  logic [periph_pkg::DataWidth-1:0]    pwdata_i,
    input  logic                                psel_i,
    input  logic                                penable_i,
    input  logic                                pwrite_i,
    output logic [periph_pkg::DataWidth-1:0]    prdata_o,
    output logic                                pready_o,
    output logic                                pslverr_o,
    // Board pins
    input  logic [periph_pkg::LedWidth-1:0]     dip_i,
    output logic [periph_pkg::LedWidth-1:0]     leds_o,
    input  logic [1:0]                          irq_src_i,
    output logic                                irq_o
);

    periph_pkg::periph_req_t front_req;
    periph_pkg::periph_req_t dec_req;
    periph_pkg::periph_rsp_t gpio_rsp;
    periph_pkg::periph_rsp_t rng_rsp;
    periph_pkg::periph_rsp_t irq_rsp;
    periph_pkg::periph_rsp_t sel_rsp;

    logic                          rng_full;
    logic [periph_pkg::NumIrq-1:0] irq_src;

    // External pins first, FIFO full on the top ID
    assign irq_src[1:0]                    = irq_src_i;
    assign irq_src[periph_pkg::IrqIdRng-1] = rng_full;

    // ------------------------------------------------------------------
    // Pipeline stages
    // ------------------------------------------------------------------
    apb_front u_front (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .req_o       (front_req),
        .rsp_i       (sel_rsp),
        .rsp_valid_i (dec_req.valid)  // Targets answer in the same cycle
    );

    periph_decode u_decode (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (front_req),
        .req_o   (dec_req)
    );

    // ------------------------------------------------------------------
    // Targets
    // ------------------------------------------------------------------
    gpio_regs u_gpio (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (dec_req),
        .rsp_o   (gpio_rsp),
        .dip_i   (dip_i),
        .leds_o  (leds_o)
    );

    rng_fifo #(
        .RngDepth (RngDepth)
    ) u_rng (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (dec_req),
        .rsp_o   (rng_rsp),
        .full_o  (rng_full)
    );

    irq_gateway u_irq (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (dec_req),
        .rsp_o   (irq_rsp),
        .src_i   (irq_src),
        .irq_o   (irq_o)
    );

    // Response mux
    always_comb
    begin
        case (dec_req.target)
            periph_pkg::TgtGpio: sel_rsp = gpio_rsp;
            periph_pkg::TgtRng:  sel_rsp = rng_rsp;
            periph_pkg::TgtIrq:  sel_rsp = irq_rsp;
            default:             sel_rsp = '{rdata: periph_pkg::BadData, error: 1'b1};
        endcase
    end

endmodule

/* hw/rng_fifo.sv */
// Random number source.
// A 32-bit LFSR steps every cycle while enabled and fills a word FIFO.
// Data read pops the FIFO, status read gives full, empty and count.
`timescale 1ns/10ps

module rng_fifo #(
    parameter int RngDepth = 8
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  periph_pkg::periph_req_t req_i,
    output periph_pkg::periph_rsp_t rsp_o,
    output logic                    full_o
);

    localparam int PtrWidth = $clog2(RngDepth);
    localparam int CntWidth = $clog2(RngDepth + 1);
    localparam int StatPad  = periph_pkg::DataWidth - 2 - CntWidth;

    logic [periph_pkg::DataWidth-1:0] mem_q [RngDepth];
    logic [periph_pkg::DataWidth-1:0] lfsr_q;
    logic [PtrWidth-1:0]              wr_ptr_q;
    logic [PtrWidth-1:0]              rd_ptr_q;
    logic [CntWidth-1:0]              count_q;
    logic                             enable_q;
    logic                             sel, empty, push, pop;

    assign sel    = req_i.valid && (req_i.target == periph_pkg::TgtRng);
    assign full_o = (count_q == CntWidth'(RngDepth));
    assign empty  = (count_q == '0);
    assign push   = enable_q && !full_o;
    assign pop    = sel && !req_i.write && (req_i.addr == periph_pkg::OffRngData) && !empty;

    // ------------------------------------------------------------------
    // Generator and FIFO control
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            enable_q <= 1'b0;
            lfsr_q   <= 32'hACE1_2468;                     // Any nonzero seed
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (sel && req_i.write && (req_i.addr == periph_pkg::OffRngStat))
                enable_q <= req_i.wdata[0];
            if (enable_q)                                  // Galois, x^32+x^22+x^2+x+1
                lfsr_q <= {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
            if (push)
                wr_ptr_q <= (wr_ptr_q == PtrWidth'(RngDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
            if (pop)
                rd_ptr_q <= (rd_ptr_q == PtrWidth'(RngDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
            count_q <= count_q + CntWidth'(push) - CntWidth'(pop);
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (push)
            mem_q[wr_ptr_q] <= lfsr_q;
    end

    // Response
    always_comb
    begin
        rsp_o.rdata = periph_pkg::BadData;
        rsp_o.error = 1'b1;
        case (req_i.addr)
            periph_pkg::OffRngData:
                if (!req_i.write && !empty)
                begin
                    rsp_o.rdata = mem_q[rd_ptr_q];
                    rsp_o.error = 1'b0;
                end
            periph_pkg::OffRngStat:
            begin
                rsp_o.rdata = {full_o, empty, {StatPad{1'b0}}, count_q};
                rsp_o.error = 1'b0;
            end
            default: ;
        endcase
    end

    // Equal pointers with data in the FIFO means the storage is full
    a_no_overflow : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        push |-> ((wr_ptr_q != rd_ptr_q) || empty)
    );

    // Equal pointers without a full count means nothing is stored
    a_no_underflow : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        pop |-> ((wr_ptr_q != rd_ptr_q) || full_o)
    );

endmodule

/* verification/periph_stimulus.txt */
# Columns (hex): kind addr data expect err. Kinds: W write, R read, P pins, D wait cycles
# R: data is a compare mask. P: data[7:0] dip, data[9:8] irq pins. D: expect leds_o, err irq_o
# GPIO
P 00 0000005A 00000000 0
W 00 000000A5 00000000 0
D 00 00000001 000000A5 0
R 00 FFFFFFFF 000000A5 0
R 04 FFFFFFFF 0000005A 0
W 04 12345678 00000000 1
P 00 000000C3 00000000 0
R 04 FFFFFFFF 000000C3 0
# RNG status, fill, then drain with the generator off
R 0C FFFFFFFF 40000000 0
W 0C 00000001 00000000 0
D 00 00000014 000000A5 0
R 0C FFFFFFFF 80000008 0
W 0C 00000000 00000000 0
R 08 00000000 00000000 0
R 0C FFFFFFFF 00000007 0
R 08 00000000 00000000 0
R 0C FFFFFFFF 00000006 0
R 08 00000000 00000000 0
R 0C FFFFFFFF 00000005 0
R 08 00000000 00000000 0
R 08 00000000 00000000 0
R 08 00000000 00000000 0
R 08 00000000 00000000 0
R 08 00000000 00000000 0
R 0C FFFFFFFF 40000000 0
R 08 FFFFFFFF DEADBEEF 1
# Interrupt claim and complete
P 00 000003C3 00000000 0
W 10 00000003 00000000 0
D 00 00000001 000000A5 1
R 14 FFFFFFFF 00000007 0
R 18 FFFFFFFF 00000001 0
R 18 FFFFFFFF 00000002 0
R 18 FFFFFFFF 00000000 0
D 00 00000001 000000A5 0
W 18 00000001 00000000 0
R 14 FFFFFFFF 00000005 0
D 00 00000001 000000A5 1
W 14 00000007 00000000 1
W 10 00000000 00000000 0
D 00 00000001 000000A5 0
W 10 00000004 00000000 0
D 00 00000001 000000A5 1
R 18 FFFFFFFF 00000003 0
D 00 00000001 000000A5 0
W 18 00000002 00000000 0
W 18 00000003 00000000 0
# Unmapped and misaligned offsets
R 20 FFFFFFFF DEADBEEF 1
W 20 00000001 00000000 1
R 02 FFFFFFFF DEADBEEF 1

/* verification/periph_tb.sv */
// Testbench for the APB peripheral block.
// Replays the stimulus file against periph_top: APB writes and reads with
// expected data and PSLVERR, pin settings, and waits that check LEDs and IRQ.
`timescale 1ns/10ps

module periph_tb;

    localparam int    ClkHalf     = 5;
    localparam int    ResetCycles = 5;
    localparam int    MaxOps      = 256;
    localparam int    ApbLatency  = 3;   // Access phase to PREADY
    localparam int    ReadyWait   = 10;
    localparam string StimFile    = "verification/periph_stimulus.txt";

    logic                                clk;
    logic                                rst_n;
    logic [periph_pkg::AddrWidth-1:0]    paddr;
    logic [periph_pkg::DataWidth-1:0]    pwdata;
    logic                                psel;
    logic                                penable;
    logic                                pwrite;
    logic [periph_pkg::DataWidth-1:0]    prdata;
    logic                                pready;
    logic                                pslverr;
    logic [periph_pkg::LedWidth-1:0]     dip;
    logic [periph_pkg::LedWidth-1:0]     leds;
    logic [1:0]                          irq_src;
    logic                                irq;

    // Operations as read from the file
    logic [7:0]  op_kind [MaxOps];
    logic [7:0]  op_addr [MaxOps];
    logic [31:0] op_data [MaxOps];
    logic [31:0] op_exp  [MaxOps];
    logic [31:0] op_err  [MaxOps];

    int num_ops     = 0;
    int check_count = 0;
    int error_count = 0;
    int cycle_count = 0;
    int cycle_limit = 0;   // Zero until the stimulus is loaded

    periph_top #(
        .RngDepth (8)
    ) UUT (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr),
        .dip_i     (dip),
        .leds_o    (leds),
        .irq_src_i (irq_src),
        .irq_o     (irq)
    );

    initial
    begin
        clk = 1'b0;
        forever #ClkHalf clk = ~clk;
    end

    // Watchdog
    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit)
        begin
            $display("Timeout: run went past %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Stimulus file
    // ------------------------------------------------------------------
    task automatic load_stimulus();
        int          fd;
        int          rc;
        string       line;
        logic [7:0]  kind;
        logic [7:0]  addr;
        logic [31:0] data;
        logic [31:0] expv;
        logic [31:0] errv;
        fd = $fopen(StimFile, "r");
        if (fd == 0)
        begin
            $display("Could not open stimulus file %s", StimFile);
            error_count++;
            return;
        end
        while (!$feof(fd) && num_ops < MaxOps)
        begin
            rc = $fgets(line, fd);
            if (rc > 1 && line.getc(0) != "#")   // Skip blank and comment lines
            begin
                rc = $sscanf(line, "%s %h %h %h %h", kind, addr, data, expv, errv);
                if (rc == 5)
                begin
                    op_kind[num_ops] = kind;
                    op_addr[num_ops] = addr;
                    op_data[num_ops] = data;
                    op_exp[num_ops]  = expv;
                    op_err[num_ops]  = errv;
                    num_ops++;
                end
                else
                begin
                    $display("Malformed stimulus line: %s", line);
                    error_count++;
                end
            end
        end
        $fclose(fd);
        if (num_ops == 0)
        begin
            $display("Stimulus file holds no operations");
            error_count++;
        end
    endtask

    // ------------------------------------------------------------------
    // APB master
    // ------------------------------------------------------------------
    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic slverr, output int latency);
        psel    = 1'b1;    // Setup phase
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;    // Access phase
        latency = 0;
        do
        begin
            @(posedge clk);
            #1;
            latency++;
        end
        while (!pready && latency < ReadyWait);
        if (!pready)
            latency = -1;
        rdata  = prdata;
        slverr = pslverr;
        @(posedge clk);    // Completion edge, signals still held
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic run_op(input int idx);
        logic [31:0] rdata;
        logic        slverr;
        int          latency;
        int          errors_before;
        logic        is_write;
        errors_before = error_count;
        is_write      = (op_kind[idx] == "W");
        case (op_kind[idx])
            "W", "R":
            begin
                apb_access(is_write, op_addr[idx], op_data[idx], rdata, slverr, latency);
                check_count++;
                if (latency < 0)
                begin
                    $display("No PREADY within %0d cycles of the access phase", ReadyWait);
                    error_count++;
                end
                else if (latency != ApbLatency)
                begin
                    $display("PREADY came %0d cycles into the access phase, not %0d",
                             latency, ApbLatency);
                    error_count++;
                end
                check_count++;
                if (slverr !== op_err[idx][0])
                begin
                    $display("MISMATCH pslverr_o: got 0x%0h, expected 0x%0h",
                             slverr, op_err[idx][0]);
                    error_count++;
                end
                // An empty mask leaves the data unchecked
                if (!is_write && (op_data[idx] != '0))
                begin
                    check_count++;
                    if ((rdata & op_data[idx]) !== (op_exp[idx] & op_data[idx]))
                    begin
                        $display("MISMATCH prdata_o: got 0x%08h, expected 0x%08h, mask 0x%08h",
                                 rdata, op_exp[idx], op_data[idx]);
                        error_count++;
                    end
                end
            end
            "P":
            begin
                dip     = op_data[idx][7:0];
                irq_src = op_data[idx][9:8];
            end
            "D":
            begin
                repeat (op_data[idx]) @(posedge clk);
                #1;
                check_count++;
                if (leds !== op_exp[idx][7:0])
                begin
                    $display("MISMATCH leds_o: got 0x%02h, expected 0x%02h",
                             leds, op_exp[idx][7:0]);
                    error_count++;
                end
                check_count++;
                if (irq !== op_err[idx][0])
                begin
                    $display("MISMATCH irq_o: got 0x%0h, expected 0x%0h", irq, op_err[idx][0]);
                    error_count++;
                end
            end
            default:
            begin
                $display("Unknown operation kind %s in the stimulus", op_kind[idx]);
                error_count++;
            end
        endcase
        if (error_count == errors_before)
            $display("op %0d %s 0x%02h: ok", idx, op_kind[idx], op_addr[idx]);
        else
            $display("op %0d %s 0x%02h: FAILED", idx, op_kind[idx], op_addr[idx]);
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial
    begin
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        dip     = '0;
        irq_src = '0;
        load_stimulus();
        // Ten cycles per operation plus the waits, then a margin
        for (int i = 0; i < num_ops; i++)
        begin
            cycle_limit += 10;
            if (op_kind[i] == "D")
                cycle_limit += int'(op_data[i]);
        end
        cycle_limit += ResetCycles + 100;
        repeat (ResetCycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < num_ops; i++)
            run_op(i);
        $display("Summary: %0d operations, %0d checks, %0d errors",
                 num_ops, check_count, error_count);
        if (error_count == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule
